//--- src/atom_bus_pkg.sv
// Atom bus and memory map types
package atom_bus_pkg;

   // ====================
   // Plain bus widths
   // ====================

   // 6502 address and data
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  cpu_data_t;

   // External SRAM is 256K, so 18 address bits
   typedef logic [17:0] ram_addr_t;

   // Bank number held in the BFFF latch
   typedef logic [2:0]  rom_bank_t;

   // ====================
   // Bus request
   // ====================

   // One CPU access as seen by the glue
   typedef struct packed {
      cpu_addr_t address;
      cpu_data_t wdata;
      logic      rnw;
   } bus_req_t;

   // Decoded regions of the memory map
   // Dropped devices (VIA, SPI, SID, video) decode as other
   typedef enum logic [2:0] {
      region_ram       = 3'd0,
      region_pia       = 3'd1,
      region_pl8       = 3'd2,
      region_rom_latch = 3'd3,
      region_other     = 3'd4
   } region_e;

   // Result of decoding one address
   typedef struct packed {
      region_e   region;
      logic      rom_cs;
      ram_addr_t ram_addr;
   } decode_t;

endpackage

//--- src/atom_io_pkg.sv
// Atom PIA and keyboard types
package atom_io_pkg;

   // ====================
   // CPU speed
   // ====================

   // Turbo setting, nominal CPU clock
   typedef enum logic [1:0] {
      mhz1 = 2'd0,
      mhz2 = 2'd1,
      mhz4 = 2'd2,
      mhz8 = 2'd3
   } turbo_e;

   // ====================
   // 8255 PIA
   // ====================

   // Full 8-bit port value
   typedef logic [7:0] pia_port_t;

   // Only the low half of port C is an output on the Atom
   typedef logic [3:0] pia_pc_low_t;

   // Port B, driven by the keyboard side
   typedef struct packed {
      logic       shift_n;
      logic       ctrl_n;
      logic [5:0] keyout;
   } kbd_in_t;

   // Writable PIA registers
   // Port A selects keyboard row and VDG mode
   typedef struct packed {
      pia_port_t   pa;
      pia_pc_low_t pc_low;
   } pia_state_t;

endpackage

//--- src/clken_gen.sv
// CPU clock enable generator
module clken_gen
   import atom_io_pkg::*;
#(
   parameter int CLKDIV_PERIOD = 25
)
(
   input  logic   clk25,
   input  logic   reset,
   input  turbo_e turbo,
   output logic   cpu_clken
);

   localparam int CNT_W = $clog2(CLKDIV_PERIOD);
   localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(CLKDIV_PERIOD - 1);
   // Enables only fire in the first 16 slots of the frame
   localparam logic [CNT_W-1:0] EN_WINDOW = CNT_W'(16);

   logic [CNT_W-1:0] clkdiv;
   logic             low_zero;

   // Number of low counter bits that must be zero per speed
   always_comb
   begin
      case (turbo)
         mhz1:    low_zero = (clkdiv[3:0] == 4'd0);
         mhz2:    low_zero = (clkdiv[2:0] == 3'd0);
         mhz4:    low_zero = (clkdiv[1:0] == 2'd0);
         default: low_zero = (clkdiv[0] == 1'b0);
      endcase
   end

   // Frame counter and registered enable
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         clkdiv    <= '0;
         cpu_clken <= 1'b0;
      end
      else
      begin
         if (clkdiv == LAST_COUNT)
            clkdiv <= '0;
         else
            clkdiv <= clkdiv + 1'b1;
         cpu_clken <= low_zero && (clkdiv < EN_WINDOW);
      end
   end

endmodule

//--- src/bus_decode.sv
// Atom memory map decoder
module bus_decode
   import atom_bus_pkg::*;
(
   input  bus_req_t  bus_req,
   input  rom_bank_t rom_bank,
   output decode_t   dec
);

   // ====================
   // Memory map
   // ====================
   // 0000-7FFF  RAM (00E7 lock flag snooped, still RAM)
   // 8000-97FF  video RAM, dropped
   // A000-AFFF  banked RAM or ROM
   // B000-B00F  8255 PIA
   // B400-B40F  empty slot, reads zero
   // B800, BC00, BD00  dropped devices
   // BFFF       ROM bank latch
   // C000-FFFF  ROM

   cpu_addr_t addr;
   logic      a000_cs;
   logic      vid_cs;
   logic      dropped_cs;

   assign addr = bus_req.address;

   // Banked window
   assign a000_cs = (addr[15:12] == 4'ha);

   // Former video RAM area
   assign vid_cs = (addr[15:12] == 4'h8) || (addr[15:11] == 5'b10010);

   // Slots of the devices no longer present
   assign dropped_cs = (addr[15:4] == 12'hb80) || (addr[15:4] == 12'hbc0) ||
                       (addr[15:8] == 8'hbd) || vid_cs;

   always_comb
   begin
      // Region, priority order as in the Atom glue
      if (addr[15:4] == 12'hb00)
         dec.region = region_pia;
      else if (addr[15:4] == 12'hb40)
         dec.region = region_pl8;
      else if (addr == 16'hbfff)
         dec.region = region_rom_latch;
      else if (dropped_cs)
         dec.region = region_other;
      else
         dec.region = region_ram;

      // Top 16K always ROM, A000 only when bank 7 is not selected
      dec.rom_cs = (addr[15:14] == 2'b11) || (a000_cs && (rom_bank != 3'd7));

      // Bank number lands in SRAM address bits 14..12
      if (a000_cs)
         dec.ram_addr = {3'b010, rom_bank, addr[11:0]};
      else
         dec.ram_addr = {2'b00, addr};
   end

endmodule

//--- src/io_execute.sv
// PIA, ROM latch and lock registers
module io_execute
   import atom_bus_pkg::*;
   import atom_io_pkg::*;
(
   input  logic       clk25,
   input  logic       reset,
   input  logic       bus_strobe,
   input  bus_req_t   bus_req,
   input  decode_t    dec,
   output pia_state_t pia,
   output rom_bank_t  rom_bank,
   output logic       lock
);

   // Address of the OS lock flag in zero page
   localparam cpu_addr_t LOCK_ADDR = 16'h00e7;

   logic      wr_en;
   logic [1:0] offset;
   cpu_data_t wdata;

   // Write accepted in the strobe cycle
   assign wr_en  = bus_strobe && !bus_req.rnw;
   assign offset = bus_req.address[1:0];
   assign wdata  = bus_req.wdata;

   // ====================
   // 8255 PIA
   // ====================

   // Port directions are fixed, so only A and low C are stored
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         pia <= '0;
      else if (wr_en && (dec.region == region_pia))
      begin
         case (offset)
            2'd0: pia.pa <= wdata;
            2'd2: pia.pc_low <= wdata[3:0];
            2'd3:
            begin
               // Control word with bit 7 clear is a port C bit set/reset
               if (!wdata[7])
                  pia.pc_low[wdata[2:1]] <= wdata[0];
            end
            default:
            begin
               // Port B is input only
            end
         endcase
      end
   end

   // ====================
   // ROM latch
   // ====================

   // Only the bank bits are kept
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         rom_bank <= '0;
      else if (wr_en && (dec.region == region_rom_latch))
         rom_bank <= wdata[2:0];
   end

   // Snoop of the lock flag, bit 5 of 00E7
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         lock <= 1'b0;
      else if (wr_en && (bus_req.address == LOCK_ADDR))
         lock <= wdata[5];
   end

endmodule

//--- src/cassette_tone.sv
// Cassette tone divider
module cassette_tone
   import atom_io_pkg::*;
#(
   parameter int CAS_DIVIDE = 208
)
(
   input  logic        clk25,
   input  logic        reset,
   input  logic        cpu_clken,
   input  pia_pc_low_t pc_low,
   output logic        cas_tone,
   output logic        cas_out
);

   // Atom divides 4MHz by 16, 13 and 8; 208 CPU enables at 1MHz is close enough
   localparam int DIV_W = $clog2(CAS_DIVIDE);
   localparam logic [DIV_W-1:0] LAST_DIV = DIV_W'(CAS_DIVIDE - 1);

   logic [DIV_W-1:0] cas_div;

   // Half-period counter, advances on CPU enables only
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_div == LAST_DIV)
         begin
            cas_div  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_div <= cas_div + 1'b1;
      end
   end

   // PC0 enables the output, PC1 gates the tone through
   assign cas_out = !(pc_low[0] && pc_low[1] && !cas_tone);

endmodule

//--- src/read_result.sv
// Read data mux and SRAM strobes
module read_result
   import atom_bus_pkg::*;
   import atom_io_pkg::*;
(
   input  logic       clk25,
   input  logic       reset,
   input  logic       bus_strobe,
   input  logic       rnw,
   input  decode_t    dec,
   input  pia_state_t pia,
   input  kbd_in_t    kbd,
   input  logic [3:0] pc_high,
   input  rom_bank_t  rom_bank,
   input  cpu_data_t  ram_rdata,
   output logic       rd_valid,
   output cpu_data_t  rd_data,
   output ram_addr_t  ram_addr,
   output logic       ram_we,
   output logic       ram_oe
);

   logic [1:0] offset;
   cpu_data_t  rd_value;
   logic       read_q;

   // Outside A000 the SRAM address carries the CPU address unchanged
   assign offset = dec.ram_addr[1:0];

   // ====================
   // Data mux
   // ====================

   always_comb
   begin
      case (dec.region)
         region_pia:
         begin
            case (offset)
               2'd0:    rd_value = pia.pa;
               2'd1:    rd_value = kbd;
               2'd2:    rd_value = {pc_high, pia.pc_low};
               default: rd_value = '0;
            endcase
         end
         // Empty slot at B40x
         region_pl8:       rd_value = '0;
         region_rom_latch: rd_value = {5'b00000, rom_bank};
         // RAM, ROM and the dropped device slots
         default:          rd_value = ram_rdata;
      endcase
   end

   // Result and SRAM control, one cycle after the strobe
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         read_q   <= 1'b0;
         ram_we   <= 1'b0;
         rd_data  <= '0;
         ram_addr <= '0;
      end
      else
      begin
         read_q <= bus_strobe && rnw;
         // ROM space is write protected
         ram_we <= bus_strobe && !rnw && !dec.rom_cs;
         if (bus_strobe)
            ram_addr <= dec.ram_addr;
         if (bus_strobe && rnw)
            rd_data <= rd_value;
      end
   end

   // SRAM output enable follows every read
   assign rd_valid = read_q;
   assign ram_oe   = read_q;

endmodule

//--- src/atom_glue_top.sv
// Atom bus glue top level
module atom_glue_top
   import atom_bus_pkg::*;
   import atom_io_pkg::*;
#(
   parameter int CLKDIV_PERIOD = 25,
   parameter int CAS_DIVIDE    = 208
)
(
   input  logic      clk25,
   input  logic      reset,
   input  turbo_e    turbo,
   // CPU side bus
   input  logic      bus_strobe,
   input  bus_req_t  bus_req,
   input  cpu_data_t ram_rdata,
   // Keyboard and cassette inputs
   input  kbd_in_t   kbd,
   input  logic      cas_in,
   input  logic      rept_n,
   input  logic      fs_n,
   output logic      cpu_clken,
   output logic      rd_valid,
   output cpu_data_t rd_data,
   // External SRAM
   output ram_addr_t ram_addr,
   output logic      ram_we,
   output logic      ram_oe,
   output logic      cas_out,
   output logic      lock
);

   decode_t    dec;
   pia_state_t pia;
   rom_bank_t  rom_bank;
   logic       cas_tone;
   logic [3:0] pc_high;

   // ====================
   // Clocking
   // ====================

   clken_gen #(
      .CLKDIV_PERIOD (CLKDIV_PERIOD)
   ) clken_gen_i (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .cpu_clken (cpu_clken)
   );

   // ====================
   // Decode and registers
   // ====================

   bus_decode bus_decode_i (
      .bus_req  (bus_req),
      .rom_bank (rom_bank),
      .dec      (dec)
   );

   io_execute io_execute_i (
      .clk25      (clk25),
      .reset      (reset),
      .bus_strobe (bus_strobe),
      .bus_req    (bus_req),
      .dec        (dec),
      .pia        (pia),
      .rom_bank   (rom_bank),
      .lock       (lock)
   );

   cassette_tone #(
      .CAS_DIVIDE (CAS_DIVIDE)
   ) cassette_tone_i (
      .clk25     (clk25),
      .reset     (reset),
      .cpu_clken (cpu_clken),
      .pc_low    (pia.pc_low),
      .cas_tone  (cas_tone),
      .cas_out   (cas_out)
   );

   // Port C inputs, bit 7 down to bit 4
   assign pc_high = {fs_n, rept_n, cas_in, cas_tone};

   read_result read_result_i (
      .clk25      (clk25),
      .reset      (reset),
      .bus_strobe (bus_strobe),
      .rnw        (bus_req.rnw),
      .dec        (dec),
      .pia        (pia),
      .kbd        (kbd),
      .pc_high    (pc_high),
      .rom_bank   (rom_bank),
      .ram_rdata  (ram_rdata),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .ram_addr   (ram_addr),
      .ram_we     (ram_we),
      .ram_oe     (ram_oe)
   );

endmodule

//--- test/tb_model.svh
// Testbench reference model
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ====================
// Random source
// ====================

logic [31:0] lfsr_state = 32'h83cd4dc1;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] r;
   int          i;
   r = '0;
   for (i = 0; i < n; i++)
   begin
      r = {r[30:0], lfsr_state[0]};
      if (lfsr_state[0])
         lfsr_state = (lfsr_state >> 1) ^ 32'hd0000001;
      else
         lfsr_state = lfsr_state >> 1;
   end
   return r;
endfunction

// ====================
// Register model
// ====================

pia_port_t   m_pa       = '0;
pia_pc_low_t m_pc_low   = '0;
rom_bank_t   m_rom_bank = '0;
logic        m_lock     = 1'b0;

// Atom memory map regions
function automatic region_e model_region(input cpu_addr_t a);
   if (a >= 16'hb000 && a <= 16'hb00f)
      return region_pia;
   if (a >= 16'hb400 && a <= 16'hb40f)
      return region_pl8;
   if (a == 16'hbfff)
      return region_rom_latch;
   return region_ram;
endfunction

function automatic logic in_bank_window(input cpu_addr_t a);
   return (a >= 16'ha000 && a <= 16'hafff);
endfunction

// Top 16K, plus A000 block unless bank 7
function automatic logic model_rom_cs(input cpu_addr_t a, input rom_bank_t bank);
   return (a >= 16'hc000) || (in_bank_window(a) && bank != 3'd7);
endfunction

function automatic ram_addr_t model_ram_addr(input cpu_addr_t a, input rom_bank_t bank);
   if (in_bank_window(a))
      return {3'b010, bank, a[11:0]};
   return {2'b00, a};
endfunction

// Expected read byte for one access
function automatic cpu_data_t model_read(input cpu_addr_t a, input cpu_data_t ram_val,
                                         input cpu_data_t kbd_val, input logic [3:0] pc_high);
   cpu_data_t v;
   v = ram_val;
   if (model_region(a) == region_pia)
   begin
      if (a[1:0] == 2'd0)
         v = m_pa;
      else if (a[1:0] == 2'd1)
         v = kbd_val;
      else if (a[1:0] == 2'd2)
         v = {pc_high, m_pc_low};
      else
         v = 8'h00;
   end
   else if (model_region(a) == region_pl8)
      v = 8'h00;
   else if (model_region(a) == region_rom_latch)
      v = {5'b00000, m_rom_bank};
   return v;
endfunction

// Register updates from one write
function automatic void model_write(input cpu_addr_t a, input cpu_data_t d);
   if (model_region(a) == region_pia)
   begin
      if (a[1:0] == 2'd0)
         m_pa = d;
      else if (a[1:0] == 2'd2)
         m_pc_low = d[3:0];
      // Bit set/reset form of the control word
      else if (a[1:0] == 2'd3 && !d[7])
         m_pc_low[d[2:1]] = d[0];
   end
   if (a == 16'hbfff)
      m_rom_bank = d[2:0];
   if (a == 16'h00e7)
      m_lock = d[5];
endfunction

// ====================
// Compare
// ====================

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
   if (actual !== expected)
   begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", name);
   end
endtask

`endif

//--- test/tb_atom_glue.sv
// Atom glue testbench
module tb_atom_glue
   import atom_bus_pkg::*;
   import atom_io_pkg::*;
();

   // Test lengths
   localparam int CAS_DIVIDE = 208;
   localparam int N_READS    = 150;
   localparam int N_PIA      = 40;
   localparam int N_BANKS    = 16;
   localparam int N_BANK_ACC = 8;
   localparam int N_LOCK     = 16;
   localparam int TONE_ON    = 2000;
   localparam int TONE_OFF   = 700;
   localparam int N_ACCESS   = N_READS + 3 * N_PIA + N_BANKS * (2 + N_BANK_ACC) + N_LOCK + 2;
   // Access takes at most 4 cycles, clock enable test 253 per speed
   localparam int CYCLE_LIMIT = 3 + 4 * 253 + 4 * N_ACCESS + TONE_ON + TONE_OFF + 200;

   logic      clk25 = 1'b0;
   logic      reset;
   turbo_e    turbo;
   logic      bus_strobe;
   bus_req_t  bus_req;
   cpu_data_t ram_rdata;
   kbd_in_t   kbd;
   logic      cas_in;
   logic      rept_n;
   logic      fs_n;
   logic      cpu_clken;
   logic      rd_valid;
   cpu_data_t rd_data;
   ram_addr_t ram_addr;
   logic      ram_we;
   logic      ram_oe;
   logic      cas_out;
   logic      lock;

   // Tone model state
   int   tone_count;
   logic m_tone;
   int   cycle_count = 0;

   `include "tb_model.svh"

   atom_glue_top #(
      .CLKDIV_PERIOD (25),
      .CAS_DIVIDE    (CAS_DIVIDE)
   ) dut_i (
      .clk25      (clk25),
      .reset      (reset),
      .turbo      (turbo),
      .bus_strobe (bus_strobe),
      .bus_req    (bus_req),
      .ram_rdata  (ram_rdata),
      .kbd        (kbd),
      .cas_in     (cas_in),
      .rept_n     (rept_n),
      .fs_n       (fs_n),
      .cpu_clken  (cpu_clken),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .ram_addr   (ram_addr),
      .ram_we     (ram_we),
      .ram_oe     (ram_oe),
      .cas_out    (cas_out),
      .lock       (lock)
   );

   always #50 clk25 = !clk25;

   // Tone flips after every CAS_DIVIDE enables
   always @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         tone_count <= 0;
         m_tone     <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (tone_count == CAS_DIVIDE - 1)
         begin
            tone_count <= 0;
            m_tone     <= !m_tone;
         end
         else
            tone_count <= tone_count + 1;
      end
   end

   // Run limit
   always @(posedge clk25)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $fatal(1, "Timeout");
      end
   end

   // Address biased toward the named regions
   function automatic cpu_addr_t pick_addr();
      logic [2:0] kind;
      cpu_addr_t  a;
      kind = 3'(rand_bits(3));
      a    = 16'(rand_bits(16));
      case (kind)
         3'd0:    a = {12'hb00, a[3:0]};
         3'd1:    a = {12'hb40, a[3:0]};
         3'd2:    a = 16'hbfff;
         3'd3:    a = {4'ha, a[11:0]};
         3'd4:    a = {2'b11, a[13:0]};
         3'd5:    a = 16'h00e7;
         default: a = a;
      endcase
      return a;
   endfunction

   // One strobed access, checked in the two cycles after it
   task automatic bus_access(input cpu_addr_t addr, input cpu_data_t wdata, input logic rnw);
      cpu_data_t  rdata;
      cpu_data_t  kbd_val;
      logic [2:0] pins;
      cpu_data_t  exp_data;
      ram_addr_t  exp_addr;
      logic       exp_we;
      rdata    = 8'(rand_bits(8));
      kbd_val  = 8'(rand_bits(8));
      pins     = 3'(rand_bits(3));
      exp_addr = model_ram_addr(addr, m_rom_bank);
      exp_we   = !rnw && !model_rom_cs(addr, m_rom_bank);
      @(posedge clk25);
      bus_strobe <= 1'b1;
      // Address, write data, read flag
      bus_req    <= {addr, wdata, rnw};
      ram_rdata  <= rdata;
      kbd        <= kbd_in_t'(kbd_val);
      {fs_n, rept_n, cas_in} <= pins;
      @(negedge clk25);
      // Port C high half sees the tone of the strobe cycle
      exp_data = model_read(addr, rdata, kbd_val, {pins, m_tone});
      @(posedge clk25);
      bus_strobe <= 1'b0;
      @(negedge clk25);
      if (!rnw)
         model_write(addr, wdata);
      check_value("rd_valid", 32'(rd_valid), 32'(rnw));
      check_value("ram_oe", 32'(ram_oe), 32'(rnw));
      check_value("ram_we", 32'(ram_we), 32'(exp_we));
      check_value("ram_addr", 32'(ram_addr), 32'(exp_addr));
      check_value("lock", 32'(lock), 32'(m_lock));
      if (rnw)
         check_value("rd_data", 32'(rd_data), 32'(exp_data));
      @(negedge clk25);
      // Strobes last one cycle only
      check_value("rd_valid", 32'(rd_valid), 32'd0);
      check_value("ram_oe", 32'(ram_oe), 32'd0);
      check_value("ram_we", 32'(ram_we), 32'd0);
   endtask

   initial
   begin
      int         t;
      int         count;
      logic [1:0] off;
      logic       prev;
      cpu_addr_t  a;
      reset      = 1'b1;
      turbo      = mhz1;
      bus_strobe = 1'b0;
      bus_req    = '0;
      ram_rdata  = '0;
      kbd        = '1;
      cas_in     = 1'b0;
      rept_n     = 1'b1;
      fs_n       = 1'b1;
      repeat (3) @(posedge clk25);
      reset <= 1'b0;

      // ====================
      // Clock enable rates
      // ====================
      for (t = 0; t < 4; t++)
      begin
         @(posedge clk25);
         turbo <= turbo_e'(2'(t));
         repeat (2) @(posedge clk25);
         count = 0;
         repeat (250)
         begin
            @(negedge clk25);
            if (cpu_clken)
               count++;
         end
         // 1, 2, 4 or 8 pulses per frame
         check_value("cpu_clken count", 32'(count), 32'(10 * (1 << t)));
      end

      // Random reads over the map
      repeat (N_READS)
         bus_access(pick_addr(), 8'h00, 1'b1);

      // PIA writes with readback, offset 3 drawn twice as often
      repeat (N_PIA)
      begin
         off = 2'(rand_bits(2));
         if (off == 2'd1)
            off = 2'd3;
         bus_access({12'hb00, 2'(rand_bits(2)), off}, 8'(rand_bits(8)), 1'b0);
         bus_access(16'hb000, 8'h00, 1'b1);
         bus_access(16'hb002, 8'h00, 1'b1);
      end

      // ====================
      // ROM banks
      // ====================
      for (t = 0; t < N_BANKS; t++)
      begin
         // First pass opens bank 7 as RAM
         bus_access(16'hbfff, (t == 0) ? 8'hf7 : 8'(rand_bits(8)), 1'b0);
         bus_access(16'hbfff, 8'h00, 1'b1);
         repeat (N_BANK_ACC)
         begin
            a = 16'(rand_bits(16));
            if (rand_bits(1) == 32'd1)
               a = {4'ha, a[11:0]};
            else
               a = {2'b11, a[13:0]};
            bus_access(a, 8'(rand_bits(8)), 1'(rand_bits(1)));
         end
      end

      // Lock flag snoop
      repeat (N_LOCK)
         bus_access(16'h00e7, 8'(rand_bits(8)), 1'b0);

      // ====================
      // Cassette output
      // ====================
      @(posedge clk25);
      turbo <= mhz8;
      bus_access(16'hb002, 8'h03, 1'b0);
      prev  = cas_out;
      count = 0;
      repeat (TONE_ON)
      begin
         @(negedge clk25);
         // Gate open, so output follows the tone
         check_value("cas_out", 32'(cas_out), 32'(m_tone));
         if (cas_out != prev)
            count++;
         prev = cas_out;
      end
      check_value("cas_out toggled at least twice", 32'(count >= 2), 32'd1);
      bus_access(16'hb002, 8'h00, 1'b0);
      repeat (TONE_OFF)
      begin
         @(negedge clk25);
         check_value("cas_out", 32'(cas_out), 32'd1);
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- tb.f
+incdir+test
src/atom_bus_pkg.sv
src/atom_io_pkg.sv
src/clken_gen.sv
src/bus_decode.sv
src/io_execute.sv
src/cassette_tone.sv
src/read_result.sv
src/atom_glue_top.sv
test/tb_atom_glue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Atom glue testbench with Verilator

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_atom_glue -o tb_atom_glue_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_atom_glue_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   echo "Test run reported a failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "Simulator exited with status $run_status"
   exit 1
fi

echo "Test run passed"
exit 0
